// ==== Makefile ====
SIM     = verilator
TOP     = tb_chunk_fetch
FLIST   = chunk_fetch_top.f
FLAGS   = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep -v '^+' $(FLIST)) tb_chunk_ref.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== chunk_fetch_top.f ====
+incdir+.
chunk_pkg.sv
row_scan.sv
chunk_row.sv
cmd_fifo.sv
chunk_fetch_top.sv
tb_chunk_fetch.sv

// ==== chunk_fetch_top.sv ====
// top level of the row chunker
// host starts a frame with a four-phase req/ack, commands leave over rdy/ack
// o_start_ack rises once the final command of the frame has been taken

`timescale 1ns/10ps

module chunk_fetch_top import chunk_pkg::*; #(
	parameter int FIFO_DEPTH  = 4,
	parameter int MAX_ROWS_BW = 8
) (
	input  logic         i_clk,
	input  logic         i_rst_n,
	input  logic         i_start_req,
	output logic         o_start_ack,
	input  window_desc_t i_desc,
	output logic         o_cmd_rdy,
	output chunk_cmd_t   o_cmd,
	input  logic         i_cmd_ack
);

	// ==============================
	// frame start / end
	// ==============================
	logic busy_r;
	logic ack_r;
	logic go;
	logic frame_end;

	// new frame only with ack low and nothing running
	assign go          = i_start_req && !busy_r && !ack_r;
	assign frame_end   = o_cmd_rdy && i_cmd_ack && o_cmd.islast;
	assign o_start_ack = ack_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			busy_r <= 1'b0;
			ack_r  <= 1'b0;
		end else if (go) begin
			busy_r <= 1'b1;
		end else if (frame_end) begin
			busy_r <= 1'b0;
			ack_r  <= 1'b1;
		end else if (!i_start_req) begin
			// host dropped req, close the handshake
			ack_r <= 1'b0;
		end
	end

	// ==============================
	// pipeline
	// ==============================
	logic       row_rdy;
	logic       row_ack;
	row_desc_t  row;
	logic       ch_rdy;
	logic       ch_ack;
	chunk_cmd_t ch_cmd;

	row_scan #(.MAX_ROWS_BW(MAX_ROWS_BW)) u_scan (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_go(go), .i_desc(i_desc),
		.o_row_rdy(row_rdy), .o_row(row), .i_row_ack(row_ack), .o_done()
	);

	chunk_row u_chunk (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_row_rdy(row_rdy), .i_row(row), .o_row_ack(row_ack),
		.o_cmd_rdy(ch_rdy), .o_cmd(ch_cmd), .i_cmd_ack(ch_ack)
	);

	cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_in_rdy(ch_rdy), .i_in(ch_cmd), .o_in_ack(ch_ack),
		.o_out_rdy(o_cmd_rdy), .o_out(o_cmd), .i_out_ack(i_cmd_ack)
	);

endmodule

// ==== chunk_pkg.sv ====
// shared widths, command encoding and descriptor types for the row chunker
// every block of the tensor-fetch chunker imports this package

package chunk_pkg;

	// ==============================
	// widths
	// ==============================
	// element address width, linear global memory
	localparam int GLOBAL_ADDR_BW = 16;
	// elements per cache line, power of two
	localparam int CACHE_SIZE = 32;
	// max elements in one command
	localparam int VSIZE = 8;

	// derived
	// offset inside a cache line
	localparam int C_BW = $clog2(CACHE_SIZE);
	// trailing pad count
	localparam int V_BW = $clog2(VSIZE);
	// command length, 1..VSIZE
	localparam int V_BW1 = $clog2(VSIZE + 1);

	// ==============================
	// command type
	// ==============================
	typedef enum logic [1:0] {
		CMD_FETCH = 2'd0,
		CMD_WRAP  = 2'd1,
		CMD_ZERO  = 2'd2
	} cmd_type_e;

	// ==============================
	// descriptors
	// ==============================
	// window over global memory, set by the host per frame
	typedef struct packed {
		logic [GLOBAL_ADDR_BW-1:0] base;
		logic [GLOBAL_ADDR_BW-1:0] stride;
		logic [GLOBAL_ADDR_BW-1:0] n_rows;
		logic [GLOBAL_ADDR_BW-1:0] first_valid;
		logic [GLOBAL_ADDR_BW-1:0] last_valid;
		// two's complement, may be negative
		logic [GLOBAL_ADDR_BW-1:0] l;
		logic [GLOBAL_ADDR_BW-1:0] n;
		logic [GLOBAL_ADDR_BW-1:0] bound;
		logic [V_BW-1:0]           pad;
		logic                      wrap;
	} window_desc_t;

	// one row, row scanner to chunk stage
	typedef struct packed {
		logic [GLOBAL_ADDR_BW-1:0] linear;
		logic                      islast;
		logic [V_BW-1:0]           pad;
		logic                      valid;
		logic [GLOBAL_ADDR_BW-1:0] l;
		logic [GLOBAL_ADDR_BW-1:0] n;
		logic [GLOBAL_ADDR_BW-1:0] bound;
		logic                      wrap;
	} row_desc_t;

	// one fetch command
	// addr is line aligned, addrofs is the element inside that line
	typedef struct packed {
		cmd_type_e                 cmd_type;
		logic                      islast;
		logic [GLOBAL_ADDR_BW-1:0] addr;
		logic [C_BW-1:0]           addrofs;
		logic [V_BW1-1:0]          len;
	} chunk_cmd_t;

endpackage

// ==== chunk_row.sv ====
// chunk stage of the row chunker
// splits one row descriptor into left border, center, right border and pad
// commands, issued in that order over rdy/ack. one init cycle per row picks
// the first kind of work, then one command per cycle while the sink acks

`timescale 1ns/10ps

module chunk_row import chunk_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_row_rdy,
	input  row_desc_t  i_row,
	output logic       o_row_ack,
	output logic       o_cmd_rdy,
	output chunk_cmd_t o_cmd,
	input  logic       i_cmd_ack
);

	localparam int GBW = GLOBAL_ADDR_BW;

	// ==============================
	// signals
	// ==============================
	// row taken, init cycle already spent
	logic           started_r;
	logic           init_v;
	logic           cmd_fire;
	logic           invalid_row;

	// row geometry
	logic [GBW-1:0] pos_l;
	logic [GBW-1:0] pos_r;
	logic [GBW-1:0] pos_b;
	logic [GBW-1:0] lb_end;
	logic [GBW-1:0] ctr_start;
	logic [GBW-1:0] ctr_end;

	// work kinds, bit 0 lborder, 1 center, 2 rborder, 3 pad
	logic [3:0]     work_flags;
	logic [3:0]     work_todo;
	logic [3:0]     next_sel;
	logic           no_next;
	logic [3:0]     sel_r;
	logic [3:0]     done_r;

	// cursor and current command
	logic [GBW-1:0]     cur_r;
	logic [GBW-1:0]     cur_addr;
	logic [GBW-1:0]     stage_end;
	logic [GBW-1:0]     cur_step;
	logic [GBW-1:0]     step_end;
	logic [GBW-C_BW-1:0] line_nxt;
	logic [GBW-1:0]     align_end;
	logic [GBW-1:0]     cmd_end;
	logic [GBW-1:0]     span;
	logic [GBW-1:0]     next_start;
	logic               stage_last;
	cmd_type_e          border_type;
	cmd_type_e          cur_type;

	// ==============================
	// init stage and handshake
	// ==============================
	// first cycle of a row is spent picking work, no command yet
	assign init_v    = i_row_rdy && !started_r;
	assign o_cmd_rdy = i_row_rdy && started_r;
	assign cmd_fire  = o_cmd_rdy && i_cmd_ack;
	// row retires with its final command
	assign o_row_ack = cmd_fire && stage_last && no_next;

	// ==============================
	// row geometry and work flags
	// ==============================
	//        linear          B
	//          |----valid----|
	//     |---------wanted--------|
	//     L                       R
	assign invalid_row = !(i_row.valid || i_row.wrap);
	assign pos_l = i_row.linear + i_row.l;
	assign pos_r = pos_l + i_row.n;
	assign pos_b = i_row.linear + i_row.bound;
	assign border_type = i_row.wrap ? CMD_WRAP : CMD_ZERO;

	always_comb begin
		// left border stops at R when the span never reaches the row
		if ($signed(pos_r) < $signed(i_row.linear) || invalid_row)
			lb_end = pos_r;
		else
			lb_end = i_row.linear;
		ctr_start = ($signed(pos_l) > $signed(i_row.linear)) ? pos_l : i_row.linear;
		ctr_end   = ($signed(pos_r) < $signed(pos_b)) ? pos_r : pos_b;

		work_flags[0] = i_row.l[GBW-1] || invalid_row;
		// center needs R strictly past linear, else it is empty
		work_flags[1] = !invalid_row && ($signed(pos_r) > $signed(i_row.linear))
			&& ($signed(i_row.l) < $signed(i_row.bound));
		work_flags[2] = !invalid_row && ($signed(pos_r) > $signed(pos_b));
		work_flags[3] = i_row.pad != '0;
	end

	// lowest-first pick among kinds not yet done
	assign work_todo = work_flags & ~done_r;
	assign next_sel  = work_todo & (~work_todo + 4'd1);
	assign no_next   = work_todo == 4'd0;

	// ==============================
	// current command
	// ==============================
	always_comb begin
		// defaults cover pad and idle
		stage_end = pos_r;
		cur_addr  = cur_r;
		cur_type  = CMD_ZERO;
		if (sel_r[0]) begin
			stage_end = lb_end;
			cur_addr  = i_row.linear;
			cur_type  = border_type;
		end else if (sel_r[1]) begin
			stage_end = ctr_end;
			cur_type  = CMD_FETCH;
		end else if (sel_r[2]) begin
			// right edge element is B-1
			cur_addr  = pos_b - GBW'(1);
			cur_type  = border_type;
		end
	end

	always_comb begin
		cur_step  = cur_r + GBW'(VSIZE);
		step_end  = ($signed(cur_step) >= $signed(stage_end)) ? stage_end : cur_step;
		// next cache line boundary, only cuts the center
		line_nxt  = cur_r[GBW-1:C_BW] + 1'b1;
		align_end = {line_nxt, {C_BW{1'b0}}};
		if (sel_r[1] && $signed(align_end) < $signed(step_end))
			cmd_end = align_end;
		else
			cmd_end = step_end;
		span       = cmd_end - cur_r;
		stage_last = sel_r[3] || (cmd_end == stage_end);

		// where the cursor starts for the kind picked next
		if (next_sel[0])
			next_start = pos_l;
		else if (next_sel[1])
			next_start = ctr_start;
		else if (next_sel[2])
			next_start = pos_b;
		else
			next_start = cur_addr; // pad keeps last address issued
	end

	always_comb begin
		o_cmd.cmd_type = cur_type;
		o_cmd.islast   = i_row.islast && stage_last && no_next;
		o_cmd.addr     = {cur_addr[GBW-1:C_BW], {C_BW{1'b0}}};
		o_cmd.addrofs  = cur_addr[C_BW-1:0];
		o_cmd.len      = sel_r[3] ? V_BW1'(i_row.pad) : span[V_BW1-1:0];
	end

	// ==============================
	// sequential
	// ==============================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			started_r <= 1'b0;
			sel_r     <= '0;
			done_r    <= '0;
		end else if (init_v) begin
			started_r <= 1'b1;
			sel_r     <= next_sel;
			done_r    <= next_sel;
		end else if (cmd_fire && stage_last) begin
			if (no_next) begin
				// row finished, wait for the next one
				started_r <= 1'b0;
				sel_r     <= '0;
				done_r    <= '0;
			end else begin
				sel_r  <= next_sel;
				done_r <= done_r | next_sel;
			end
		end
	end

	// cursor
	always_ff @(posedge i_clk) begin
		if (init_v || (cmd_fire && stage_last && !no_next))
			cur_r <= next_start;
		else if (cmd_fire)
			cur_r <= cmd_end;
	end

	// ==============================
	// checks
	// ==============================
	// an active row always works on exactly one kind
	assert property (@(posedge i_clk) disable iff (!i_rst_n) started_r |-> $onehot(sel_r))
		else $error("work kind selection not one-hot on an active row");
	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_cmd_rdy |-> o_cmd.len != '0)
		else $error("zero length command offered");

endmodule

// ==== cmd_fifo.sv ====
// command queue between the chunk stage and the output port
// circular buffer, rdy/ack on both sides, one cycle of latency when empty
// input is not acked while the queue is full

`timescale 1ns/10ps

module cmd_fifo import chunk_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_in_rdy,
	input  chunk_cmd_t i_in,
	output logic       o_in_ack,
	output logic       o_out_rdy,
	output chunk_cmd_t o_out,
	input  logic       i_out_ack
);

	localparam int PTR_BW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_BW = $clog2(FIFO_DEPTH + 1);

	// ==============================
	// storage and pointers
	// ==============================
	chunk_cmd_t        mem [FIFO_DEPTH];
	logic [PTR_BW-1:0] wr_ptr_r;
	logic [PTR_BW-1:0] rd_ptr_r;
	logic [CNT_BW-1:0] cnt_r;

	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	assign full  = cnt_r == CNT_BW'(FIFO_DEPTH);
	assign empty = cnt_r == '0;
	assign do_wr = i_in_rdy && o_in_ack;
	assign do_rd = o_out_rdy && i_out_ack;

	assign o_in_ack  = i_in_rdy && !full;
	assign o_out_rdy = !empty;
	assign o_out     = mem[rd_ptr_r];

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_BW-1:0] ptr_inc(input logic [PTR_BW-1:0] p);
		if (p == PTR_BW'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			cnt_r    <= '0;
		end else begin
			if (do_wr)
				wr_ptr_r <= ptr_inc(wr_ptr_r);
			if (do_rd)
				rd_ptr_r <= ptr_inc(rd_ptr_r);
			// simultaneous read and write keeps the count
			if (do_wr && !do_rd)
				cnt_r <= cnt_r + 1'b1;
			else if (do_rd && !do_wr)
				cnt_r <= cnt_r - 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (do_wr)
			mem[wr_ptr_r] <= i_in;
	end

	// ==============================
	// checks
	// ==============================
	// count never runs past the depth
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		cnt_r <= CNT_BW'(FIFO_DEPTH))
		else $error("write into a full command queue");
	// consumer side must only ack an offered command
	assert property (@(posedge i_clk) disable iff (!i_rst_n) i_out_ack |-> o_out_rdy)
		else $error("read from an empty command queue");

endmodule

// ==== row_scan.sv ====
// row scanner of the chunker
// walks the rows of one frame and offers a row descriptor per row (rdy/ack)
// i_desc must stay stable for the whole frame, which the start handshake ensures

`timescale 1ns/10ps

module row_scan import chunk_pkg::*; #(
	parameter int MAX_ROWS_BW = 8
) (
	input  logic         i_clk,
	input  logic         i_rst_n,
	input  logic         i_go,
	input  window_desc_t i_desc,
	output logic         o_row_rdy,
	output row_desc_t    o_row,
	input  logic         i_row_ack,
	output logic         o_done
);

	// ==============================
	// state
	// ==============================
	logic                      rdy_r;
	logic                      done_r;
	logic [MAX_ROWS_BW-1:0]    row_cnt_r;
	// running linear address of the current row
	logic [GLOBAL_ADDR_BW-1:0] linear_r;

	logic [GLOBAL_ADDR_BW-1:0] row_idx;
	logic                      row_last;
	logic                      row_fire;

	// counter widened for compares against the descriptor
	assign row_idx  = GLOBAL_ADDR_BW'(row_cnt_r);
	assign row_last = row_idx == i_desc.n_rows - GLOBAL_ADDR_BW'(1);
	assign row_fire = rdy_r && i_row_ack;

	assign o_row_rdy = rdy_r;
	assign o_done    = done_r;

	// ==============================
	// row descriptor
	// ==============================
	always_comb begin
		o_row.linear = linear_r;
		o_row.islast = row_last;
		o_row.pad    = i_desc.pad;
		// valid only inside first_valid..last_valid
		o_row.valid  = (row_idx >= i_desc.first_valid) && (row_idx <= i_desc.last_valid);
		o_row.l      = i_desc.l;
		o_row.n      = i_desc.n;
		o_row.bound  = i_desc.bound;
		o_row.wrap   = i_desc.wrap;
	end

	// ==============================
	// control
	// ==============================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rdy_r  <= 1'b0;
			done_r <= 1'b0;
		end else begin
			// single cycle pulse after the last row leaves
			done_r <= row_fire && row_last;
			if (i_go) begin
				rdy_r <= 1'b1;
			end else if (row_fire && row_last) begin
				rdy_r <= 1'b0;
			end
		end
	end

	// counter and address, only meaningful while rdy_r
	always_ff @(posedge i_clk) begin
		if (i_go) begin
			row_cnt_r <= '0;
			linear_r  <= i_desc.base;
		end else if (row_fire) begin
			row_cnt_r <= row_cnt_r + 1'b1;
			// next row by stride, no multiply
			linear_r  <= linear_r + i_desc.stride;
		end
	end

	// ==============================
	// checks
	// ==============================
	// held row must not change, relies on the host keeping i_desc stable too
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_row_rdy && !i_row_ack |=> $stable(o_row))
		else $error("row descriptor changed while waiting for ack");

endmodule

// ==== tb_chunk_ref.svh ====
// reference model for the chunker testbench
// expands a window descriptor into the expected command list, row by row
// included inside the testbench module; results are appended to exp_q

`ifndef TB_CHUNK_REF_SVH
`define TB_CHUNK_REF_SVH

// expected commands, oldest first
chunk_cmd_t exp_q[$];
// full element address of the last command added
int         last_addr;

// one command onto the expected list
function automatic void add_cmd(input cmd_type_e t, input int a, input int len);
	chunk_cmd_t c;
	c.cmd_type = t;
	c.islast   = 1'b0;
	c.addr     = GLOBAL_ADDR_BW'(a - (a % CACHE_SIZE));
	c.addrofs  = C_BW'(a % CACHE_SIZE);
	c.len      = V_BW1'(len);
	exp_q.push_back(c);
	last_addr = a;
endfunction

// cut [start, stop) into commands of at most VSIZE elements
// fixed >= 0 pins every address (borders), lines also cuts at cache lines
function automatic void add_span(input cmd_type_e t, input int start, input int stop,
		input int fixed, input bit lines);
	int cur;
	int e;
	int line_end;
	cur = start;
	while (cur < stop) begin
		e = cur + VSIZE;
		if (e > stop)
			e = stop;
		line_end = (cur / CACHE_SIZE + 1) * CACHE_SIZE;
		if (lines && line_end < e)
			e = line_end;
		add_cmd(t, (fixed >= 0) ? fixed : cur, e - cur);
		cur = e;
	end
endfunction

// whole frame: left border, center, right border, pad for each row
function automatic void expand_frame(input window_desc_t d);
	int         k;
	int         lin;
	int         lp;
	int         rp;
	int         bp;
	int         l_s;
	bit         valid;
	bit         invalid;
	cmd_type_e  bt;
	chunk_cmd_t c;
	l_s = int'($signed(d.l));
	bt  = d.wrap ? CMD_WRAP : CMD_ZERO;
	for (k = 0; k < int'(d.n_rows); k++) begin
		lin     = int'(d.base) + k * int'(d.stride);
		lp      = lin + l_s;
		rp      = lp + int'(d.n);
		bp      = lin + int'(d.bound);
		valid   = (k >= int'(d.first_valid)) && (k <= int'(d.last_valid));
		invalid = !valid && !d.wrap;
		// left border, whole span on an invalid row
		if (l_s < 0 || invalid)
			add_span(bt, lp, (rp < lin || invalid) ? rp : lin, lin, 1'b0);
		// center, clipped to the valid part of the row
		if (!invalid && rp >= lin && l_s < int'(d.bound))
			add_span(CMD_FETCH, (lp > lin) ? lp : lin, (rp < bp) ? rp : bp, -1, 1'b1);
		// right border repeats element B-1
		if (rp > bp && !invalid)
			add_span(bt, bp, rp, bp - 1, 1'b0);
		if (d.pad != 0)
			add_cmd(CMD_ZERO, last_addr, int'(d.pad));
	end
	// only the final command of the frame carries islast
	c        = exp_q.pop_back();
	c.islast = 1'b1;
	exp_q.push_back(c);
endfunction

`endif

// ==== tb_chunk_fetch.sv ====
// testbench for the row chunker top level
// runs a set of frames through the four-phase start handshake, stalls the
// command output at random and checks each command against the reference model

`timescale 1ns/10ps

module tb_chunk_fetch import chunk_pkg::*; ();

	localparam int N_FRAMES = 6;

	logic         clk;
	logic         rst_n;
	logic         start_req;
	logic         start_ack;
	window_desc_t desc;
	logic         cmd_rdy;
	chunk_cmd_t   cmd;
	logic         cmd_ack = 1'b0;

	`include "tb_chunk_ref.svh"

	window_desc_t frames [N_FRAMES];
	chunk_cmd_t   exp_c;
	logic [31:0]  rng = 32'hcc7;
	logic         ack_seen = 1'b0;
	int           val_errs = 0;
	int           seq_errs = 0;
	int           hs_errs = 0;
	int           n_cmds = 0;
	int           cycle_cnt = 0;
	int           cycle_limit = 200;
	int           f;
	int           total;

	chunk_fetch_top #(.FIFO_DEPTH(4), .MAX_ROWS_BW(8)) dut (
		.i_clk(clk), .i_rst_n(rst_n), .i_start_req(start_req), .o_start_ack(start_ack),
		.i_desc(desc), .o_cmd_rdy(cmd_rdy), .o_cmd(cmd), .i_cmd_ack(cmd_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic window_desc_t make_desc(input int base, input int stride,
			input int rows, input int fv, input int lv, input int l, input int n,
			input int bound, input int pad, input bit wrap);
		window_desc_t d;
		d.base        = 16'(base);
		d.stride      = 16'(stride);
		d.n_rows      = 16'(rows);
		d.first_valid = 16'(fv);
		d.last_valid  = 16'(lv);
		d.l           = 16'(l);
		d.n           = 16'(n);
		d.bound       = 16'(bound);
		d.pad         = V_BW'(pad);
		d.wrap        = wrap;
		return d;
	endfunction

	task automatic report_value(input string name, input int got, input int expected);
		$display("FAILED %s got %h expected %h (command %0d)", name, got, expected, n_cmds);
		val_errs++;
	endtask

	// ==============================
	// output sink
	// ==============================
	// ack only after a cycle without a transfer, so the queue cannot run dry under ack
	always @(posedge clk) begin
		if (!rst_n) begin
			rng     <= 32'hcc7;
			cmd_ack <= 1'b0;
		end else begin
			rng     <= xorshift(rng);
			cmd_ack <= cmd_rdy && !cmd_ack && (rng[1:0] != 2'b00);
		end
	end

	// compare every transfer with the expected list
	always @(posedge clk) begin
		if (rst_n && cmd_rdy && cmd_ack) begin
			if (exp_q.size() == 0) begin
				$display("unexpected command at %0t, nothing left in the expected list", $time);
				seq_errs++;
			end else begin
				exp_c = exp_q.pop_front();
				if (cmd.cmd_type != exp_c.cmd_type)
					report_value("o_cmd.cmd_type", cmd.cmd_type, exp_c.cmd_type);
				if (cmd.islast != exp_c.islast)
					report_value("o_cmd.islast", cmd.islast, exp_c.islast);
				if (cmd.addr != exp_c.addr)
					report_value("o_cmd.addr", cmd.addr, exp_c.addr);
				if (cmd.addrofs != exp_c.addrofs)
					report_value("o_cmd.addrofs", cmd.addrofs, exp_c.addrofs);
				if (cmd.len != exp_c.len)
					report_value("o_cmd.len", cmd.len, exp_c.len);
			end
			if (cmd.cmd_type == CMD_FETCH
					&& int'(cmd.addrofs) + int'(cmd.len) > CACHE_SIZE) begin
				$display("fetch command %0d crosses a cache line", n_cmds);
				seq_errs++;
			end
			if (int'(cmd.len) > VSIZE) begin
				$display("command %0d is longer than VSIZE", n_cmds);
				seq_errs++;
			end
			n_cmds++;
		end
		// frame ack must not rise while commands are still owed
		if (rst_n && start_ack && !ack_seen && exp_q.size() != 0) begin
			$display("start ack rose with %0d commands still expected", exp_q.size());
			seq_errs++;
		end
		ack_seen <= start_ack;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, %0d commands never arrived", cycle_cnt,
				exp_q.size());
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ==============================
	// frames
	// ==============================
	// four phases: req up, ack up, req down, ack down
	task automatic run_frame(input window_desc_t d);
		expand_frame(d);
		@(posedge clk);
		desc      <= d;
		start_req <= 1'b1;
		@(posedge clk);
		while (!start_ack)
			@(posedge clk);
		start_req <= 1'b0;
		@(posedge clk);
		// ack still held until the dropped req is seen
		if (!start_ack) begin
			$display("start ack fell before the request was released");
			hs_errs++;
		end
		while (start_ack)
			@(posedge clk);
		if (exp_q.size() != 0) begin
			$display("frame closed with %0d commands missing", exp_q.size());
			hs_errs++;
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		start_req = 1'b0;
		desc      = '0;
		// inside, wrap borders, zero borders, invalid rows, pad, pad with borders
		frames[0] = make_desc('h100, 'h40, 3, 0, 2, 5, 40, 60, 0, 1'b0);
		frames[1] = make_desc('h200, 'h30, 2, 0, 0, -5, 50, 40, 0, 1'b1);
		frames[2] = make_desc('h200, 'h30, 2, 0, 1, -12, 60, 40, 0, 1'b0);
		frames[3] = make_desc('h300, 'h20, 4, 1, 2, -3, 20, 16, 0, 1'b0);
		frames[4] = make_desc('h400, 'h28, 2, 0, 1, 2, 20, 30, 5, 1'b1);
		frames[5] = make_desc('h500, 'h1c, 3, 1, 1, -4, 30, 20, 3, 1'b0);
		// four cycles per expected command plus slack
		total = 0;
		for (f = 0; f < N_FRAMES; f++) begin
			expand_frame(frames[f]);
			total += exp_q.size();
			exp_q.delete();
		end
		cycle_limit = total * 4 + 200;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (f = 0; f < N_FRAMES; f++)
			run_frame(frames[f]);
		repeat (4) @(posedge clk);
		$display("errors: value %0d, sequence %0d, handshake %0d; commands %0d of %0d",
			val_errs, seq_errs, hs_errs, n_cmds, total);
		if (val_errs + seq_errs + hs_errs == 0 && n_cmds == total)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
